//--- Bender.yml
package:
  name: intra_nb

sources:
  - intra_nb_pkg.sv
  - intra_nb_decode.sv
  - intra_nb_fetch.sv
  - intra_nb_store.sv
  - intra_nb_result.sv
  - intra_nb_top.sv
  - target: test
    files:
      - tb_intra_nb_checker.sv
      - tb_intra_nb_assert.sv
      - tb_intra_nb.sv

export_include_dirs: []

dependencies: {}

//--- filelist.f
intra_nb_pkg.sv
intra_nb_decode.sv
intra_nb_fetch.sv
intra_nb_store.sv
intra_nb_result.sv
intra_nb_top.sv
tb_intra_nb_checker.sv
tb_intra_nb_assert.sv
tb_intra_nb.sv

//--- intra_nb_decode.sv
`timescale 1ns/1ns
`default_nettype none

module intra_nb_decode (
	input wire intra_nb_pkg::fetch_req_t fetch,
	output intra_nb_pkg::nb_plan_t plan
);

	intra_nb_pkg::blk_idx_t blk_a;
	intra_nb_pkg::blk_idx_t blk_b;
	intra_nb_pkg::blk_idx_t blk_c;
	intra_nb_pkg::blk_idx_t blk_d;
	logic left_col;  // neighbour A lies in the left mb
	logic top_row;   // neighbour B lies in the upper mb
	logic c_never;   // top-right not yet decoded
	logic [7:0] x_cur;
	logic [7:0] x_left;
	logic [7:0] x_right;
	logic par_cur;
	logic par_up;

	assign x_cur   = fetch.pos.mb_x;
	assign x_left  = fetch.pos.mb_x - 8'd1;
	assign x_right = fetch.pos.mb_x + 8'd1;
	assign par_cur = fetch.pos.mb_y[0];
	assign par_up  = ~fetch.pos.mb_y[0];

	assign left_col = (fetch.blk == 4'd0) || (fetch.blk == 4'd2) ||
		(fetch.blk == 4'd8) || (fetch.blk == 4'd10);
	assign top_row = (fetch.blk == 4'd0) || (fetch.blk == 4'd1) ||
		(fetch.blk == 4'd4) || (fetch.blk == 4'd5);
	assign c_never = (fetch.blk == 4'd3) || (fetch.blk == 4'd7) ||
		(fetch.blk == 4'd11) || (fetch.blk == 4'd13) || (fetch.blk == 4'd15);

	// neighbour block index per position, {A, B, C, D}
	always_comb begin
		case (fetch.blk)
			4'd0:    {blk_a, blk_b, blk_c, blk_d} = {4'd5, 4'd10, 4'd11, 4'd15};
			4'd1:    {blk_a, blk_b, blk_c, blk_d} = {4'd0, 4'd11, 4'd14, 4'd10};
			4'd2:    {blk_a, blk_b, blk_c, blk_d} = {4'd7, 4'd0, 4'd1, 4'd5};
			4'd3:    {blk_a, blk_b, blk_c, blk_d} = {4'd2, 4'd1, 4'd4, 4'd0};
			4'd4:    {blk_a, blk_b, blk_c, blk_d} = {4'd1, 4'd14, 4'd15, 4'd11};
			4'd5:    {blk_a, blk_b, blk_c, blk_d} = {4'd4, 4'd15, 4'd10, 4'd14};
			4'd6:    {blk_a, blk_b, blk_c, blk_d} = {4'd3, 4'd4, 4'd5, 4'd1};
			4'd7:    {blk_a, blk_b, blk_c, blk_d} = {4'd6, 4'd5, 4'd0, 4'd4};
			4'd8:    {blk_a, blk_b, blk_c, blk_d} = {4'd13, 4'd2, 4'd3, 4'd7};
			4'd9:    {blk_a, blk_b, blk_c, blk_d} = {4'd8, 4'd3, 4'd6, 4'd2};
			4'd10:   {blk_a, blk_b, blk_c, blk_d} = {4'd15, 4'd8, 4'd9, 4'd13};
			4'd11:   {blk_a, blk_b, blk_c, blk_d} = {4'd10, 4'd9, 4'd12, 4'd8};
			4'd12:   {blk_a, blk_b, blk_c, blk_d} = {4'd9, 4'd6, 4'd7, 4'd3};
			4'd13:   {blk_a, blk_b, blk_c, blk_d} = {4'd12, 4'd7, 4'd0, 4'd6};
			4'd14:   {blk_a, blk_b, blk_c, blk_d} = {4'd11, 4'd12, 4'd13, 4'd9};
			default: {blk_a, blk_b, blk_c, blk_d} = {4'd14, 4'd13, 4'd0, 4'd12};
		endcase
	end

	always_comb begin
		plan.avail_a = !(left_col && (fetch.pos.mb_x == 8'd0));
		plan.avail_b = !(top_row && (fetch.pos.mb_y == 8'd0));
		plan.avail_c = !(c_never || (top_row && (fetch.pos.mb_y == 8'd0)) ||
			((fetch.blk == 4'd5) && (fetch.pos.mb_x == fetch.pos.pic_w_m1)));
		plan.avail_d = !((top_row && (fetch.pos.mb_y == 8'd0)) ||
			(left_col && (fetch.pos.mb_x == 8'd0)));
		plan.c_subst = !plan.avail_c;

		plan.addr_a = intra_nb_pkg::blk_addr(left_col ? x_left : x_cur, par_cur, blk_a);
		plan.addr_b = intra_nb_pkg::blk_addr(x_cur, top_row ? par_up : par_cur, blk_b);
		if (plan.avail_c)
			plan.addr_c = intra_nb_pkg::blk_addr((fetch.blk == 4'd5) ? x_right : x_cur,
				top_row ? par_up : par_cur, blk_c);
		else
			plan.addr_c = plan.addr_b;  // reread top, corner gets repeated
		if (plan.avail_d)
			plan.addr_d = intra_nb_pkg::blk_addr(left_col ? x_left : x_cur,
				top_row ? par_up : par_cur, blk_d);
		else
			plan.addr_d = '0;
	end

endmodule

`default_nettype wire

//--- intra_nb_fetch.sv
`timescale 1ns/1ns
`default_nettype none

module intra_nb_fetch (
	input wire clk,
	input wire reset_n,
	input wire fetch_valid,
	input wire intra_nb_pkg::nb_plan_t plan,
	output logic rd_en,
	output logic [intra_nb_pkg::addr_w-1:0] rd_addr,
	output intra_nb_pkg::fetch_state_t step,
	output logic busy
);

	intra_nb_pkg::fetch_state_t state;
	intra_nb_pkg::nb_plan_t plan_q;
	logic accept;

	assign busy   = (state != intra_nb_pkg::idle);
	assign accept = fetch_valid && !busy;  // strobes during a walk are lost
	assign rd_en  = busy;
	assign step   = state;

	// every step takes its cycle, missing or not
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			state <= intra_nb_pkg::idle;
		end else begin
			case (state)
				intra_nb_pkg::idle: if (accept) state <= intra_nb_pkg::rd_a;
				intra_nb_pkg::rd_a: state <= intra_nb_pkg::rd_b;
				intra_nb_pkg::rd_b: state <= intra_nb_pkg::rd_c;
				intra_nb_pkg::rd_c: state <= intra_nb_pkg::rd_d;
				default:            state <= intra_nb_pkg::idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (accept)
			plan_q <= plan;
	end

	always_comb begin
		case (state)
			intra_nb_pkg::rd_a: rd_addr = plan_q.addr_a;
			intra_nb_pkg::rd_b: rd_addr = plan_q.addr_b;
			intra_nb_pkg::rd_c: rd_addr = plan_q.addr_c;
			intra_nb_pkg::rd_d: rd_addr = plan_q.addr_d;
			default:            rd_addr = '0;
		endcase
	end

endmodule

`default_nettype wire

//--- intra_nb_pkg.sv
`default_nettype none

package intra_nb_pkg;

	localparam int pix_w   = 8;
	localparam int blk_w   = 5;  // block field of the store address
	localparam int mbx_w   = 7;  // mb column bits kept in the address
	localparam int addr_w  = 13;
	localparam int tc_w    = 5;
	localparam int edge_px = 7;

	// luma 4x4 index in H.264 scan order
	typedef logic [3:0] blk_idx_t;

	typedef struct packed {
		logic [7:0] mb_x;
		logic [7:0] mb_y;
		logic [7:0] pic_w_m1;
	} mb_pos_t;

	// 0..2 right column rows 0..2, 3..5 bottom row cols 0..2, 6 corner
	typedef logic [edge_px-1:0][pix_w-1:0] edge_t;

	typedef logic [15:0][pix_w-1:0] blk_pix_t;  // row-major, index r*4+c

	typedef struct packed {
		mb_pos_t         pos;
		blk_idx_t        blk;
		blk_pix_t        pix;
		logic [tc_w-1:0] tc;
		logic            res_zero;
	} wr_req_t;

	typedef struct packed {
		mb_pos_t  pos;
		blk_idx_t blk;
	} fetch_req_t;

	typedef struct packed {
		logic [addr_w-1:0] addr_a;
		logic [addr_w-1:0] addr_b;
		logic [addr_w-1:0] addr_c;
		logic [addr_w-1:0] addr_d;
		logic              avail_a;
		logic              avail_b;
		logic              avail_c;
		logic              avail_d;
		logic              c_subst;
	} nb_plan_t;

	typedef struct packed {
		logic [pix_w-1:0] a, b, c, d, e, f, g, h, i, j, k, l, m;
		logic             avail_a;
		logic             avail_b;
		logic [tc_w-1:0]  tc_a;
		logic [tc_w-1:0]  tc_b;
	} nb_pix_t;

	typedef enum logic [2:0] {
		idle = 3'd0,
		rd_a = 3'd1,
		rd_b = 3'd2,
		rd_c = 3'd3,
		rd_d = 3'd4
	} fetch_state_t;

	// {mb column, mb row parity, block}
	function automatic logic [addr_w-1:0] blk_addr(input logic [7:0] mb_x,
			input logic row_par, input blk_idx_t blk);
		return {mb_x[mbx_w-1:0], row_par, {(blk_w - 4){1'b0}}, blk};
	endfunction

endpackage

`default_nettype wire

//--- intra_nb_result.sv
`timescale 1ns/1ns
`default_nettype none

module intra_nb_result (
	input wire clk,
	input wire reset_n,
	input wire intra_nb_pkg::fetch_state_t step,
	input wire intra_nb_pkg::nb_plan_t plan,
	input wire intra_nb_pkg::edge_t edge_rd,
	input wire [intra_nb_pkg::tc_w-1:0] tc_rd,
	output logic nb_valid,
	output intra_nb_pkg::nb_pix_t nb
);

	intra_nb_pkg::fetch_state_t step_q;  // lines up with store data
	intra_nb_pkg::nb_plan_t plan_q;

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n)
			step_q <= intra_nb_pkg::idle;
		else
			step_q <= step;
	end

	// decode output only holds during the strobe, keep it for the walk
	always_ff @(posedge clk) begin
		if (step == intra_nb_pkg::idle)
			plan_q <= plan;
	end

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			nb       <= '0;
			nb_valid <= 1'b0;
		end else begin
			nb_valid <= (step_q == intra_nb_pkg::rd_d);
			case (step_q)
				intra_nb_pkg::rd_a: begin
					nb.avail_a <= plan_q.avail_a;
					nb.i       <= plan_q.avail_a ? edge_rd[0] : '0;
					nb.j       <= plan_q.avail_a ? edge_rd[1] : '0;
					nb.k       <= plan_q.avail_a ? edge_rd[2] : '0;
					nb.l       <= plan_q.avail_a ? edge_rd[6] : '0;
					nb.tc_a    <= plan_q.avail_a ? tc_rd : '0;
				end
				intra_nb_pkg::rd_b: begin
					nb.avail_b <= plan_q.avail_b;
					nb.a       <= plan_q.avail_b ? edge_rd[3] : '0;
					nb.b       <= plan_q.avail_b ? edge_rd[4] : '0;
					nb.c       <= plan_q.avail_b ? edge_rd[5] : '0;
					nb.d       <= plan_q.avail_b ? edge_rd[6] : '0;
					nb.tc_b    <= plan_q.avail_b ? tc_rd : '0;
				end
				intra_nb_pkg::rd_c: begin
					nb.e <= plan_q.c_subst ? nb.d : edge_rd[3];  // d captured last cycle
					nb.f <= plan_q.c_subst ? nb.d : edge_rd[4];
					nb.g <= plan_q.c_subst ? nb.d : edge_rd[5];
					nb.h <= plan_q.c_subst ? nb.d : edge_rd[6];
				end
				intra_nb_pkg::rd_d: nb.m <= plan_q.avail_d ? edge_rd[6] : '0;
				default: ;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- intra_nb_store.sv
`timescale 1ns/1ns
`default_nettype none

module intra_nb_store #(
	parameter type payload_t = logic
) (
	input wire clk,
	input wire reset_n,
	input wire wr_en,
	input wire [intra_nb_pkg::addr_w-1:0] wr_addr,
	input wire payload_t wr_data,
	input wire rd_en,
	input wire [intra_nb_pkg::addr_w-1:0] rd_addr,
	output payload_t rd_data
);

	payload_t mem [2 ** intra_nb_pkg::addr_w];  // two mb rows, by parity

	always_ff @(posedge clk) begin
		if (wr_en)
			mem[wr_addr] <= wr_data;
	end

	// same-address collision returns old contents
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n)
			rd_data <= '0;
		else if (rd_en)
			rd_data <= mem[rd_addr];
	end

endmodule

`default_nettype wire

//--- intra_nb_top.sv
`timescale 1ns/1ns
`default_nettype none

module intra_nb_top (
	input wire clk,
	input wire reset_n,
	input wire wr_valid,
	input wire intra_nb_pkg::wr_req_t wr,
	input wire fetch_valid,
	input wire intra_nb_pkg::fetch_req_t fetch,
	output logic nb_valid,
	output intra_nb_pkg::nb_pix_t nb
);

	intra_nb_pkg::edge_t wr_edge;
	logic [intra_nb_pkg::tc_w-1:0] wr_tc;
	logic [intra_nb_pkg::addr_w-1:0] wr_addr;
	intra_nb_pkg::nb_plan_t plan;
	logic rd_en;
	logic [intra_nb_pkg::addr_w-1:0] rd_addr;
	intra_nb_pkg::fetch_state_t step;
	logic busy;
	intra_nb_pkg::edge_t edge_rd;
	logic [intra_nb_pkg::tc_w-1:0] tc_rd;

	// right column rows 0..2, bottom row cols 0..2, corner
	always_comb begin
		wr_edge[0] = wr.pix[3];
		wr_edge[1] = wr.pix[7];
		wr_edge[2] = wr.pix[11];
		wr_edge[3] = wr.pix[12];
		wr_edge[4] = wr.pix[13];
		wr_edge[5] = wr.pix[14];
		wr_edge[6] = wr.pix[15];
	end

	assign wr_tc   = wr.res_zero ? '0 : wr.tc;
	assign wr_addr = intra_nb_pkg::blk_addr(wr.pos.mb_x, wr.pos.mb_y[0], wr.blk);

	intra_nb_decode u_decode (
		.fetch (fetch),
		.plan  (plan)
	);

	intra_nb_fetch u_fetch (
		.clk         (clk),
		.reset_n     (reset_n),
		.fetch_valid (fetch_valid),
		.plan        (plan),
		.rd_en       (rd_en),
		.rd_addr     (rd_addr),
		.step        (step),
		.busy        (busy)
	);

	intra_nb_store #(.payload_t(intra_nb_pkg::edge_t)) u_edge_store (
		.clk (clk), .reset_n (reset_n),
		.wr_en (wr_valid), .wr_addr (wr_addr), .wr_data (wr_edge),
		.rd_en (rd_en), .rd_addr (rd_addr), .rd_data (edge_rd)
	);

	intra_nb_store #(.payload_t(logic [intra_nb_pkg::tc_w-1:0])) u_tc_store (
		.clk (clk), .reset_n (reset_n),
		.wr_en (wr_valid), .wr_addr (wr_addr), .wr_data (wr_tc),
		.rd_en (rd_en), .rd_addr (rd_addr), .rd_data (tc_rd)
	);

	intra_nb_result u_result (
		.clk      (clk),
		.reset_n  (reset_n),
		.step     (step),
		.plan     (plan),
		.edge_rd  (edge_rd),
		.tc_rd    (tc_rd),
		.nb_valid (nb_valid),
		.nb       (nb)
	);

endmodule

`default_nettype wire

//--- tb_intra_nb.sv
`timescale 1ns/1ns
`default_nettype none

module tb_intra_nb;

	logic clk;
	logic reset_n;
	logic wr_valid;
	intra_nb_pkg::wr_req_t wr;
	logic fetch_valid;
	intra_nb_pkg::fetch_req_t fetch;
	logic nb_valid;
	intra_nb_pkg::nb_pix_t nb;
	logic [31:0] rng;
	int unsigned mismatch_cnt;
	int unsigned timeout_cnt;
	int unsigned pic_w;

	intra_nb_top u_dut (
		.clk         (clk),
		.reset_n     (reset_n),
		.wr_valid    (wr_valid),
		.wr          (wr),
		.fetch_valid (fetch_valid),
		.fetch       (fetch),
		.nb_valid    (nb_valid),
		.nb          (nb)
	);

	tb_intra_nb_checker u_checker (
		.clk         (clk),
		.reset_n     (reset_n),
		.wr_valid    (wr_valid),
		.wr          (wr),
		.fetch_valid (fetch_valid),
		.fetch       (fetch),
		.nb_valid    (nb_valid),
		.nb          (nb),
		.err_cnt     (mismatch_cnt)
	);

	always #10 clk = ~clk;

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		s ^= s << 13;
		s ^= s >> 17;
		s ^= s << 5;
		return s;
	endfunction

	// one block: fetch its neighbours, then write it back
	task automatic run_block(input logic [7:0] mx, input logic [7:0] my,
			input intra_nb_pkg::blk_idx_t blk);
		intra_nb_pkg::fetch_req_t req;
		intra_nb_pkg::blk_pix_t px;
		logic seen;
		int n;
		req.pos.mb_x     = mx;
		req.pos.mb_y     = my;
		req.pos.pic_w_m1 = pic_w - 1;
		req.blk          = blk;
		@(posedge clk);
		fetch_valid <= 1'b1;
		fetch       <= req;
		@(posedge clk);
		fetch_valid <= 1'b0;
		seen = 1'b0;
		n = 0;
		while (!seen && n < 20) begin
			@(posedge clk);
			seen = nb_valid;
			n++;
		end
		if (!seen) begin
			timeout_cnt++;
			$display("timeout: no neighbour result within 20 cycles for mb (%0d,%0d) block %0d",
				mx, my, blk);
		end
		for (int p = 0; p < 16; p++) begin
			rng = xorshift(rng);
			px[p] = rng[7:0];
		end
		rng = xorshift(rng);
		wr_valid    <= 1'b1;
		wr.pos      <= req.pos;
		wr.blk      <= blk;
		wr.pix      <= px;
		wr.tc       <= rng[4:0];
		wr.res_zero <= (rng[9:8] == 2'b00);  // about one in four
		@(posedge clk);
		wr_valid <= 1'b0;
	endtask

	initial begin
		int unsigned total;
		clk = 1'b0;
		reset_n = 1'b0;
		wr_valid = 1'b0;
		wr = '0;
		fetch_valid = 1'b0;
		fetch = '0;
		timeout_cnt = 0;
		rng = 32'he44f;
		repeat (5) @(posedge clk);
		reset_n <= 1'b1;
		rng = xorshift(rng);
		pic_w = 2 + rng % 4;
		// raster mb order, scan order inside each mb
		for (int my = 0; my < 3; my++)
			for (int mx = 0; mx < pic_w; mx++)
				for (int b = 0; b < 16; b++)
					run_block(mx, my, b);
		repeat (2) @(posedge clk);
		total = mismatch_cnt + timeout_cnt + u_dut.u_assert.fail_cnt;
		$display("errors: %0d mismatches, %0d timeouts, %0d assertion failures",
			mismatch_cnt, timeout_cnt, u_dut.u_assert.fail_cnt);
		if (total == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- tb_intra_nb_assert.sv
`timescale 1ns/1ns
`default_nettype none

module tb_intra_nb_assert (
	input wire clk,
	input wire reset_n,
	input wire fetch_valid,
	input wire busy,
	input wire nb_valid,
	input wire intra_nb_pkg::nb_pix_t nb
);

	int unsigned fail_cnt = 0;

	a_valid_pulse: assert property (@(posedge clk) disable iff (!reset_n)
		nb_valid |=> !nb_valid)
		else begin
			fail_cnt++;
			$error("nb_valid stayed high for more than one cycle");
		end

	a_latency: assert property (@(posedge clk) disable iff (!reset_n)
		fetch_valid && !busy |-> ##6 nb_valid)
		else begin
			fail_cnt++;
			$error("nb_valid did not follow an accepted fetch after 6 cycles");
		end

	a_left_zero: assert property (@(posedge clk) disable iff (!reset_n)
		nb_valid && !nb.avail_a |-> (nb.i == '0 && nb.j == '0 && nb.k == '0 && nb.l == '0))
		else begin
			fail_cnt++;
			$error("left pixels not zero with neighbour A missing");
		end

endmodule

bind intra_nb_top tb_intra_nb_assert u_assert (
	.clk         (clk),
	.reset_n     (reset_n),
	.fetch_valid (fetch_valid),
	.busy        (busy),
	.nb_valid    (nb_valid),
	.nb          (nb)
);

`default_nettype wire

//--- tb_intra_nb_checker.sv
`timescale 1ns/1ns
`default_nettype none

module tb_intra_nb_checker (
	input wire clk,
	input wire reset_n,
	input wire wr_valid,
	input wire intra_nb_pkg::wr_req_t wr,
	input wire fetch_valid,
	input wire intra_nb_pkg::fetch_req_t fetch,
	input wire nb_valid,
	input wire intra_nb_pkg::nb_pix_t nb,
	output int unsigned err_cnt
);

	logic [7:0] pic [0:47][0:79];  // up to 5x3 mbs
	logic [4:0] tcg [0:11][0:19];  // one count per 4x4 block
	intra_nb_pkg::fetch_req_t req;
	logic pending;
	int unsigned cycles;

	function automatic int scan_idx(input int x, input int y);
		return {y[1], x[1], y[0], x[0]};
	endfunction

	function automatic logic [7:0] pix_at(input int x, input int y);
		if (x < 0 || y < 0 || x > 79 || y > 47)
			return 8'd0;
		return pic[y][x];
	endfunction

	task automatic compare(input string name, input logic [7:0] exp_v, input logic [7:0] act_v);
		if (exp_v !== act_v) begin
			err_cnt++;
			$display("Mismatch %s at mb (%0d,%0d) blk %0d: expected %0h, actual %0h",
				name, req.pos.mb_x, req.pos.mb_y, req.blk, exp_v, act_v);
		end
	endtask

	task automatic record_write();
		int gx;
		int gy;
		gx = wr.pos.mb_x * 4 + {wr.blk[2], wr.blk[0]};
		gy = wr.pos.mb_y * 4 + {wr.blk[3], wr.blk[1]};
		for (int r = 0; r < 4; r++)
			for (int c = 0; c < 4; c++)
				pic[gy * 4 + r][gx * 4 + c] = wr.pix[r * 4 + c];
		tcg[gy][gx] = wr.res_zero ? 5'd0 : wr.tc;
	endtask

	task automatic check_result();
		int bx;
		int by;
		int gx;
		int gy;
		int px;
		int py;
		logic av_a;
		logic av_b;
		logic av_c;
		logic av_d;
		logic [7:0] exp_px [13];
		logic [7:0] act_px [13];
		bx = {req.blk[2], req.blk[0]};
		by = {req.blk[3], req.blk[1]};
		gx = req.pos.mb_x * 4 + bx;
		gy = req.pos.mb_y * 4 + by;
		px = gx * 4;
		py = gy * 4;
		av_a = (gx > 0);
		av_b = (gy > 0);
		av_d = av_a && av_b;
		// top-right inside the picture and already decoded
		av_c = av_b && (gx + 1 < (req.pos.pic_w_m1 + 1) * 4) &&
			(by == 0 || (bx < 3 && scan_idx(bx + 1, by - 1) < req.blk));
		for (int k = 0; k < 4; k++) begin
			exp_px[k]     = av_b ? pix_at(px + k, py - 1) : 8'd0;
			exp_px[8 + k] = av_a ? pix_at(px - 1, py + k) : 8'd0;
		end
		for (int k = 0; k < 4; k++)
			exp_px[4 + k] = av_c ? pix_at(px + 4 + k, py - 1) : exp_px[3];
		exp_px[12] = av_d ? pix_at(px - 1, py - 1) : 8'd0;
		act_px = '{nb.a, nb.b, nb.c, nb.d, nb.e, nb.f, nb.g, nb.h,
			nb.i, nb.j, nb.k, nb.l, nb.m};
		for (int k = 0; k < 13; k++)
			compare($sformatf("pixel %c", 8'h61 + k), exp_px[k], act_px[k]);
		compare("avail_a", av_a, nb.avail_a);
		compare("avail_b", av_b, nb.avail_b);
		compare("tc_a", av_a ? tcg[gy][gx - 1] : 5'd0, nb.tc_a);
		compare("tc_b", av_b ? tcg[gy - 1][gx] : 5'd0, nb.tc_b);
	endtask

	always @(posedge clk) begin
		if (!reset_n) begin
			pending = 1'b0;
			cycles = 0;
			err_cnt = 0;
		end else begin
			if (pending)
				cycles++;
			if (nb_valid) begin
				if (!pending) begin
					err_cnt++;
					$display("neighbour result arrived with no fetch outstanding");
				end else begin
					compare("latency", 8'd6, cycles[7:0]);
					check_result();
					pending = 1'b0;
				end
			end
			if (fetch_valid) begin
				req = fetch;
				pending = 1'b1;
				cycles = 0;
			end
			if (wr_valid)
				record_write();
		end
	end

endmodule

`default_nettype wire
